// ==== hdl/hello_csr.sv ====
// ==============================
// AXI-lite CSR slave, one read and one write in flight at a time
// A command to a busy link stalls the write channel until it is taken
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hello_csr
#(
    parameter int NUM_LINKS  = 4,
    parameter int MEM_ADDR_W = 48
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    // AXI-lite slave
    input  logic                 awvalid,
    output logic                 awready,
    input  hello_pkg::t_csr_addr awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  hello_pkg::t_csr_data wdata,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  hello_pkg::t_csr_addr araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output hello_pkg::t_csr_data rdata,
    output logic [1:0]           rresp,

    // Per-link command channels
    hello_link_if.dispatch       links[NUM_LINKS],

    // Status from the completion collector
    input  logic [31:0]          done_count,
    input  logic [31:0]          err_count,
    input  logic [NUM_LINKS-1:0] busy_mask
);

    import hello_pkg::*;

    // Held request registers, payloads carry no reset
    logic      ar_held;
    t_csr_addr ar_addr_q;
    logic      aw_held;
    t_csr_addr aw_addr_q;
    logic      w_held;
    t_csr_data w_data_q;

    logic [31:0] reject_count;

    // ==============================
    // Read path
    // ==============================

    // A new read is accepted only with both request and response slots empty
    assign arready = !ar_held && !rvalid;
    assign rresp   = 2'b00;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ar_held <= 1'b0;
            rvalid  <= 1'b0;
        end
        else if (ar_held)
        begin
            // Held request turns into a response on this edge
            ar_held <= 1'b0;
            rvalid  <= 1'b1;
        end
        else
        begin
            if (arvalid && arready)
            begin
                ar_held <= 1'b1;
            end
            if (rvalid && rready)
            begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (arvalid && arready)
        begin
            ar_addr_q <= araddr;
        end

        // Only bits 5:3 are decoded, so the map aliases across higher addresses
        if (ar_held)
        begin
            case (t_csr_idx'(ar_addr_q[5:3]))
                CSR_LINKS:  rdata <= t_csr_data'(NUM_LINKS - 1);
                CSR_BYTES:  rdata <= t_csr_data'(LINE_BYTES);
                CSR_DONE:   rdata <= t_csr_data'(done_count);
                CSR_ERRS:   rdata <= t_csr_data'(err_count);
                CSR_REJECT: rdata <= t_csr_data'(reject_count);
                CSR_BUSY:   rdata <= t_csr_data'(busy_mask);
                default:    rdata <= '0;
            endcase
        end
    end

    // ==============================
    // Write path and command decode
    // ==============================

    logic                  both_held;
    logic                  is_cmd_addr;
    logic [3:0]            cmd_idx;
    logic                  idx_in_range;
    logic                  cmd_pending;
    logic                  cmd_fire;
    logic                  write_done;
    logic [MEM_ADDR_W-1:0] cmd_addr;
    logic [NUM_LINKS-1:0]  link_hit;
    logic [NUM_LINKS-1:0]  link_ready;
    logic [NUM_LINKS-1:0]  cmd_valid_vec;

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign bresp   = 2'b00;

    assign both_held    = aw_held && w_held;
    assign is_cmd_addr  = (aw_addr_q == '0);
    // Link index rides in the top nibble of the line address word
    assign cmd_idx      = w_data_q[63:60];
    assign idx_in_range = (cmd_idx < NUM_LINKS);
    assign cmd_pending  = both_held && is_cmd_addr && idx_in_range;
    // Host passes a line address, memory wants a byte address
    assign cmd_addr     = MEM_ADDR_W'({w_data_q, 6'b0});

    // Present the command only on the selected link
    for (genvar p = 0; p < NUM_LINKS; p++)
    begin : g_link
        assign link_hit[p]           = (cmd_idx == 4'(p));
        assign links[p].cmd_valid    = cmd_valid_vec[p];
        assign links[p].cmd_line_addr = cmd_addr;
        assign link_ready[p]         = links[p].cmd_ready;
    end

    assign cmd_valid_vec = {NUM_LINKS{cmd_pending}} & link_hit;
    assign cmd_fire      = |(cmd_valid_vec & link_ready);

    // A valid command completes only once its link takes it
    assign write_done = both_held && (!cmd_pending || cmd_fire);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
        end
        else if (write_done)
        begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b1;
        end
        else
        begin
            // Address and data may arrive in either order
            if (awvalid && awready)
            begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready)
            begin
                w_held <= 1'b1;
            end
            if (bvalid && bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (awvalid && awready)
        begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready)
        begin
            w_data_q <= wdata;
        end
    end

    // Commands naming a missing link are dropped here and counted
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            reject_count <= '0;
        end
        else if (both_held && is_cmd_addr && !idx_in_range)
        begin
            reject_count <= reject_count + 32'd1;
        end
    end

    // A read response keeps its data until the host takes it
    a_read_hold: assert property (@(posedge clk) disable iff (!reset_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // An offered command stays on the same link with the same address until taken
    a_cmd_hold: assert property (@(posedge clk) disable iff (!reset_n)
        |cmd_valid_vec && !cmd_fire |=> $stable(cmd_valid_vec) && $stable(cmd_addr));

endmodule

`default_nettype wire

// ==== hdl/hello_done_collector.sv ====
// ==============================
// Completion counters wrap at 32 bits
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hello_done_collector
#(
    parameter int NUM_LINKS = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    hello_link_if.collect        links[NUM_LINKS],
    output logic [31:0]          done_count,
    output logic [31:0]          err_count,
    output logic [NUM_LINKS-1:0] busy_mask
);

    logic [NUM_LINKS-1:0] done_vec;
    logic [NUM_LINKS-1:0] err_vec;
    logic [4:0]           done_sum;
    logic [4:0]           err_sum;

    // Flatten the interface array so the pulses can be summed
    for (genvar p = 0; p < NUM_LINKS; p++)
    begin : g_link
        assign done_vec[p]  = links[p].done;
        assign err_vec[p]   = links[p].done && links[p].done_err;
        assign busy_mask[p] = !links[p].cmd_ready;
    end

    // Several links may finish on the same cycle
    always_comb
    begin
        done_sum = '0;
        err_sum  = '0;
        for (int i = 0; i < NUM_LINKS; i++)
        begin
            done_sum = done_sum + 5'(done_vec[i]);
            err_sum  = err_sum + 5'(err_vec[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            done_count <= '0;
            err_count  <= '0;
        end
        else
        begin
            done_count <= done_count + 32'(done_sum);
            err_count  <= err_count + 32'(err_sum);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hello_link_if.sv ====
// ==============================
// One link's command and completion signals
// ==============================
`timescale 1ns/1ps
`default_nettype none

interface hello_link_if
#(
    parameter int MEM_ADDR_W = 48
);

    // Command toward the writer, held until cmd_ready is seen
    logic                  cmd_valid;
    // Byte address of the target line, always 64-byte aligned
    logic [MEM_ADDR_W-1:0] cmd_line_addr;
    // High only while the writer is idle
    logic                  cmd_ready;

    // One-cycle completion pulse, done_err qualified by done
    logic                  done;
    logic                  done_err;

    // CSR side issues commands
    modport dispatch (output cmd_valid, cmd_line_addr, input cmd_ready);

    // Writer side consumes commands and reports completion
    modport writer (input cmd_valid, cmd_line_addr, output cmd_ready, done, done_err);

    // Collector only observes
    modport collect (input cmd_ready, done, done_err);

endinterface

`default_nettype wire

// ==== hdl/hello_link_writer.sv ====
// ==============================
// Writes one greeting line per command, AW then W then B
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hello_link_writer
#(
    parameter int LINK_ID    = 0,
    parameter int MEM_ADDR_W = 48
)
(
    input  logic                            clk,
    input  logic                            reset_n,
    hello_link_if.writer                    link,

    // Host-memory write channels
    output logic                            awvalid,
    input  logic                            awready,
    output logic [MEM_ADDR_W-1:0]           awaddr,
    output logic                            wvalid,
    input  logic                            wready,
    output logic [hello_pkg::LINE_BITS-1:0] wdata,
    input  logic                            bvalid,
    output logic                            bready,
    input  logic [1:0]                      bresp
);

    import hello_pkg::*;

    // Message ends in the ASCII digit of this link and a closing parenthesis
    localparam logic [LINE_BITS-1:0] LINE_DATA =
        {{(LINE_BITS - 120){1'b0}}, 8'h29, 8'(8'h30 + LINK_ID), HELLO_MSG};

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } t_state;

    t_state                state;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic                  done_q;
    logic                  err_q;

    // Ready stays low through the completion pulse
    assign link.cmd_ready = (state == ST_IDLE) && !done_q;
    assign link.done      = done_q;
    assign link.done_err  = err_q;

    assign awvalid = (state == ST_ADDR);
    assign awaddr  = addr_q;
    assign wvalid  = (state == ST_DATA);
    assign wdata   = LINE_DATA;
    assign bready  = (state == ST_RESP);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
            case (state)
                ST_IDLE: if (link.cmd_valid && link.cmd_ready) state <= ST_ADDR;
                ST_ADDR: if (awready) state <= ST_DATA;
                ST_DATA: if (wready) state <= ST_RESP;
                ST_RESP:
                begin
                    // Any response other than OKAY is reported as an error
                    if (bvalid)
                    begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                        err_q  <= (bresp != 2'b00);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (link.cmd_valid && link.cmd_ready)
        begin
            addr_q <= link.cmd_line_addr;
        end
    end

    // The address channel stays put while the host stalls it
    a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

`default_nettype wire

// ==== hdl/hello_multi_link.sv ====
// ==============================
// Top level, NUM_LINKS from 1 to 16 sharing one clock and reset
// ==============================
`timescale 1ns/1ps
`default_nettype none

module hello_multi_link
#(
    parameter int NUM_LINKS  = 4,
    parameter int MEM_ADDR_W = 48
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    // AXI-lite CSR port
    input  logic                 awvalid,
    output logic                 awready,
    input  hello_pkg::t_csr_addr awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  hello_pkg::t_csr_data wdata,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  hello_pkg::t_csr_addr araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output hello_pkg::t_csr_data rdata,
    output logic [1:0]           rresp,

    // Host-memory write ports, one entry per link
    output logic [NUM_LINKS-1:0]                           mem_awvalid,
    input  logic [NUM_LINKS-1:0]                           mem_awready,
    output logic [NUM_LINKS-1:0][MEM_ADDR_W-1:0]           mem_awaddr,
    output logic [NUM_LINKS-1:0]                           mem_wvalid,
    input  logic [NUM_LINKS-1:0]                           mem_wready,
    output logic [NUM_LINKS-1:0][hello_pkg::LINE_BITS-1:0] mem_wdata,
    input  logic [NUM_LINKS-1:0]                           mem_bvalid,
    output logic [NUM_LINKS-1:0]                           mem_bready,
    input  logic [NUM_LINKS-1:0][1:0]                      mem_bresp
);

    logic [31:0]          done_count;
    logic [31:0]          err_count;
    logic [NUM_LINKS-1:0] busy_mask;

    hello_link_if #(.MEM_ADDR_W(MEM_ADDR_W)) links[NUM_LINKS] ();

    hello_csr #(.NUM_LINKS(NUM_LINKS), .MEM_ADDR_W(MEM_ADDR_W)) u_csr
    (
        .clk(clk), .reset_n(reset_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .links(links),
        .done_count(done_count), .err_count(err_count), .busy_mask(busy_mask)
    );

    // One writer per link, each stamping its own index into the message
    for (genvar p = 0; p < NUM_LINKS; p++)
    begin : g_writer
        hello_link_writer #(.LINK_ID(p), .MEM_ADDR_W(MEM_ADDR_W)) u_writer
        (
            .clk(clk), .reset_n(reset_n), .link(links[p]),
            .awvalid(mem_awvalid[p]), .awready(mem_awready[p]), .awaddr(mem_awaddr[p]),
            .wvalid(mem_wvalid[p]), .wready(mem_wready[p]), .wdata(mem_wdata[p]),
            .bvalid(mem_bvalid[p]), .bready(mem_bready[p]), .bresp(mem_bresp[p])
        );
    end

    hello_done_collector #(.NUM_LINKS(NUM_LINKS)) u_collector
    (
        .clk(clk), .reset_n(reset_n), .links(links),
        .done_count(done_count), .err_count(err_count), .busy_mask(busy_mask)
    );

endmodule

`default_nettype wire

// ==== hdl/hello_pkg.sv ====
// ==============================
// Shared constants and types for the multi-link hello writer
// Line width is fixed at one 64-byte host-memory line
// ==============================
`default_nettype none

package hello_pkg;

    // One host-memory line, written whole in a single W beat
    localparam int LINE_BITS  = 512;
    localparam int LINE_BYTES = LINE_BITS / 8;

    // AXI-lite CSR bus widths
    localparam int CSR_ADDR_W = 16;
    typedef logic [CSR_ADDR_W-1:0] t_csr_addr;
    typedef logic [63:0] t_csr_data;

    // Read register index, taken from byte address bits 5:3
    // Indices 6 and 7 are unassigned and read as zero
    typedef enum logic [2:0]
    {
        CSR_LINKS  = 3'd0,
        CSR_BYTES  = 3'd1,
        CSR_DONE   = 3'd2,
        CSR_ERRS   = 3'd3,
        CSR_REJECT = 3'd4,
        CSR_BUSY   = 3'd5
    } t_csr_idx;

    // ASCII "Hello world (" with the first character in the lowest byte
    localparam logic [103:0] HELLO_MSG = 104'h2820646c726f77206f6c6c6548;

endpackage

`default_nettype wire

// ==== tb/tb_hello_multi_link.sv ====
// ==============================
// Three links, host memory modeled with random ready delays
// Lines whose address bits 9:6 equal hex E get an SLVERR response
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_hello_multi_link;

    import hello_pkg::*;

    localparam int NUM_LINKS  = 3;
    localparam int MEM_ADDR_W = 48;
    localparam logic [31:0] SEED = 32'h03bfc894;

    // Row flags mark memory traffic, a rejected index, an SLVERR and a settle point
    localparam logic [3:0] F_MEM    = 4'b0001;
    localparam logic [3:0] F_REJ    = 4'b0010;
    localparam logic [3:0] F_ERR    = 4'b0100;
    localparam logic [3:0] F_SETTLE = 4'b1000;

    typedef struct packed {
        logic                  write;
        t_csr_addr             addr;
        t_csr_data             data;
        t_csr_data             exp_rd;
        logic [1:0]            link;
        logic [MEM_ADDR_W-1:0] mem_addr;
        logic [3:0]            flags;
    } row_t;

    logic clk;
    logic reset_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    t_csr_addr awaddr, araddr;
    t_csr_data wdata, rdata;
    logic [1:0] bresp, rresp;
    logic [NUM_LINKS-1:0]                  mem_awvalid, mem_awready, mem_wvalid, mem_wready;
    logic [NUM_LINKS-1:0]                  mem_bvalid, mem_bready;
    logic [NUM_LINKS-1:0][MEM_ADDR_W-1:0]  mem_awaddr;
    logic [NUM_LINKS-1:0][LINE_BITS-1:0]   mem_wdata;
    logic [NUM_LINKS-1:0][1:0]             mem_bresp;

    // What host memory saw, and what the table says it should see
    logic [MEM_ADDR_W-1:0] aw_seen [NUM_LINKS][$];
    logic [LINE_BITS-1:0]  w_seen [NUM_LINKS][$];
    logic [MEM_ADDR_W-1:0] exp_aw [NUM_LINKS][$];
    logic [31:0]           lfsr_state [NUM_LINKS];

    row_t        rows[$];
    logic        rows_ready = 1'b0;
    int unsigned error_count = 0;
    int unsigned exp_done = 0;
    int unsigned exp_errs = 0;
    int unsigned exp_rej = 0;

    hello_multi_link #(.NUM_LINKS(NUM_LINKS), .MEM_ADDR_W(MEM_ADDR_W)) UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // All stimulus changes land 1 ns after the rising edge
    task automatic step;
        @(posedge clk);
        #1;
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Two bits per draw, one LFSR step per bit
    function automatic logic [1:0] draw_delay(input int link);
        logic [1:0] d;
        for (int b = 0; b < 2; b++)
        begin
            d[b] = lfsr_state[link][0];
            lfsr_state[link] = lfsr_step(lfsr_state[link]);
        end
        return d;
    endfunction

    // Greeting text with the link digit, first character in the lowest byte
    function automatic logic [LINE_BITS-1:0] expected_line(input int k);
        string                text;
        logic [LINE_BITS-1:0] line;
        text = $sformatf("Hello world (%0d)", k);
        line = '0;
        for (int i = 0; i < text.len(); i++)
        begin
            line[8*i +: 8] = text[i];
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] actual,
                               input logic [LINE_BITS-1:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // ==============================
    // Host-memory responder, one process per link
    // ==============================
    for (genvar p = 0; p < NUM_LINKS; p++)
    begin : g_mem
        initial
        begin
            logic [1:0]            d;
            logic                  hs;
            logic [MEM_ADDR_W-1:0] addr;
            mem_awready[p] = 1'b0;
            mem_wready[p]  = 1'b0;
            mem_bvalid[p]  = 1'b0;
            mem_bresp[p]   = 2'b00;
            lfsr_state[p]  = SEED;
            wait (reset_n === 1'b1);
            forever
            begin
                step();
                if (mem_awvalid[p])
                begin
                    d = draw_delay(p);
                    repeat (d) step();
                    addr = mem_awaddr[p];
                    aw_seen[p].push_back(addr);
                    mem_awready[p] = 1'b1;
                    step();
                    mem_awready[p] = 1'b0;
                    // The data beat follows the address on its own channel
                    while (!mem_wvalid[p])
                    begin
                        step();
                    end
                    d = draw_delay(p);
                    repeat (d) step();
                    w_seen[p].push_back(mem_wdata[p]);
                    mem_wready[p] = 1'b1;
                    step();
                    mem_wready[p] = 1'b0;
                    d = draw_delay(p);
                    repeat (d) step();
                    mem_bresp[p]  = (addr[9:6] == 4'hE) ? 2'b10 : 2'b00;
                    mem_bvalid[p] = 1'b1;
                    do
                    begin
                        hs = mem_bready[p];
                        step();
                    end while (!hs);
                    mem_bvalid[p] = 1'b0;
                    mem_bresp[p]  = 2'b00;
                end
            end
        end
    end

    // ==============================
    // CSR bus tasks
    // ==============================
    task automatic axi_write(input t_csr_addr addr, input t_csr_data data);
        logic       aw_hs;
        logic       w_hs;
        logic       aw_done;
        logic       w_done;
        logic       b_hs;
        logic [1:0] resp;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!aw_done || !w_done)
        begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            step();
            if (aw_hs)
            begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs)
            begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        // A command to a busy link holds B back until the link takes it
        bready = 1'b1;
        do
        begin
            b_hs = bvalid;
            resp = bresp;
            step();
        end while (!b_hs);
        bready = 1'b0;
        check_value("bresp", resp, 2'b00);
    endtask

    task automatic axi_read(input t_csr_addr addr, output t_csr_data data);
        logic       hs;
        logic [1:0] resp;
        arvalid = 1'b1;
        araddr  = addr;
        do
        begin
            hs = arready;
            step();
        end while (!hs);
        arvalid = 1'b0;
        rready  = 1'b1;
        do
        begin
            hs   = rvalid;
            data = rdata;
            resp = rresp;
            step();
        end while (!hs);
        rready = 1'b0;
        check_value("rresp", resp, 2'b00);
    endtask

    // Wait for all links idle, then compare counters and every memory transfer
    task automatic settle_and_compare;
        t_csr_data rd;
        do
        begin
            axi_read(16'h0028, rd);
        end while (rd != 0);
        axi_read(16'h0010, rd);
        check_value("CSR_DONE", rd, exp_done);
        axi_read(16'h0018, rd);
        check_value("CSR_ERRS", rd, exp_errs);
        axi_read(16'h0020, rd);
        check_value("CSR_REJECT", rd, exp_rej);
        for (int p = 0; p < NUM_LINKS; p++)
        begin
            check_value($sformatf("mem_awaddr[%0d] count", p), aw_seen[p].size(), exp_aw[p].size());
            check_value($sformatf("mem_wdata[%0d] count", p), w_seen[p].size(), exp_aw[p].size());
            while (exp_aw[p].size() > 0)
            begin
                check_value($sformatf("mem_awaddr[%0d]", p), aw_seen[p].pop_front(),
                            exp_aw[p].pop_front());
                check_value($sformatf("mem_wdata[%0d]", p), w_seen[p].pop_front(),
                            expected_line(p));
            end
        end
    endtask

    task automatic add_row(input logic write, input t_csr_addr addr, input t_csr_data data,
                           input t_csr_data exp_rd, input logic [1:0] link,
                           input logic [MEM_ADDR_W-1:0] mem_addr, input logic [3:0] flags);
        row_t r;
        r = '{write, addr, data, exp_rd, link, mem_addr, flags};
        rows.push_back(r);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin
        row_t      row;
        t_csr_data rd;
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        // write, CSR address, CSR data, read value, link, memory address, flags
        add_row(0, 16'h0000, 64'h0, 64'd2, 0, 48'h0, 0);
        add_row(0, 16'h0008, 64'h0, 64'd64, 0, 48'h0, 0);
        add_row(0, 16'h0030, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(0, 16'h0038, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(0, 16'h1038, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(0, 16'h0070, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(0, 16'h0048, 64'h0, 64'd64, 0, 48'h0, 0);
        add_row(0, 16'h0010, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(1, 16'h0000, 64'h0000_0000_0000_0123, 0, 0, 48'h48C0, F_MEM | F_SETTLE);
        add_row(1, 16'h0000, 64'h1000_0000_0000_2001, 0, 1, 48'h80040, F_MEM | F_SETTLE);
        add_row(1, 16'h0000, 64'h2000_0000_0000_0055, 0, 2, 48'h1540, F_MEM | F_SETTLE);
        add_row(1, 16'h0000, 64'h1000_0000_0000_003E, 0, 1, 48'hF80, F_MEM | F_ERR | F_SETTLE);
        add_row(1, 16'h0000, 64'h3000_0000_0000_0010, 0, 0, 48'h0, F_REJ | F_SETTLE);
        add_row(1, 16'h0000, 64'hF000_0000_0000_0010, 0, 0, 48'h0, F_REJ | F_SETTLE);
        add_row(1, 16'h0008, 64'h1000_0000_0000_0077, 0, 0, 48'h0, F_SETTLE);
        // Back-to-back commands on link 2, only the last one settles
        add_row(1, 16'h0000, 64'h2000_0000_0000_0100, 0, 2, 48'h4000, F_MEM);
        add_row(1, 16'h0000, 64'h2000_0000_0000_0101, 0, 2, 48'h4040, F_MEM);
        add_row(1, 16'h0000, 64'h2000_0000_0000_010E, 0, 2, 48'h4380, F_MEM | F_ERR | F_SETTLE);
        add_row(1, 16'h0000, 64'h0000_0000_0000_ABCD, 0, 0, 48'h2AF340, F_MEM | F_SETTLE);
        add_row(0, 16'h0028, 64'h0, 64'd0, 0, 48'h0, 0);
        add_row(0, 16'h0020, 64'h0, 64'd2, 0, 48'h0, 0);
        add_row(0, 16'h0010, 64'h0, 64'd8, 0, 48'h0, 0);
        add_row(0, 16'h0018, 64'h0, 64'd2, 0, 48'h0, 0);
        rows_ready = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        foreach (rows[i])
        begin
            row = rows[i];
            if (row.write)
            begin
                axi_write(row.addr, row.data);
                if (row.flags & F_MEM)
                begin
                    exp_aw[row.link].push_back(row.mem_addr);
                    exp_done++;
                end
                if (row.flags & F_ERR)
                begin
                    exp_errs++;
                end
                if (row.flags & F_REJ)
                begin
                    exp_rej++;
                end
                if (row.flags & F_SETTLE)
                begin
                    settle_and_compare();
                end
            end
            else
            begin
                axi_read(row.addr, rd);
                check_value($sformatf("rdata at %0h", row.addr), rd, row.exp_rd);
            end
        end

        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    // Each row gets a generous cycle budget, including its settle reads
    initial
    begin
        wait (rows_ready);
        repeat (rows.size() * 300) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles", rows.size() * 300);
        $display("Checks failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/hello_pkg.sv
hdl/hello_link_if.sv
hdl/hello_csr.sv
hdl/hello_link_writer.sv
hdl/hello_done_collector.sv
hdl/hello_multi_link.sv
tb/tb_hello_multi_link.sv
